//--- Bender.yml
package:
  name: erx_clocks

sources:
  - files:
      - src/erx_pkg.sv
      - src/erx_reset_sync.sv
      - src/erx_reset_seq.sv
      - src/erx_clock_gen.sv
      - src/erx_cfg_regs.sv
      - src/erx_clocks.sv
  - target: test
    files:
      - verif/tb_erx_clocks.sv

//--- list.f
src/erx_pkg.sv
src/erx_reset_sync.sv
src/erx_reset_seq.sv
src/erx_clock_gen.sv
src/erx_cfg_regs.sv
src/erx_clocks.sv
verif/tb_erx_clocks.sv

//--- src/erx_cfg_regs.sv
`timescale 1ns/1ps

module erx_cfg_regs (
   input  logic               sys_clk,
   input  logic               rx_nreset_in,
   input  erx_pkg::axil_req_t axil_req,
   output erx_pkg::axil_rsp_t axil_rsp,
   input  erx_pkg::rx_status_t status,      // From the sequencer
   output logic               soft_reset    // CTRL bit 0
);

   import erx_pkg::*;

   logic                   aw_rdy;     // Shared awready and wready pulse
   logic                   b_valid;
   axil_resp_e             b_resp;
   logic                   ar_rdy;
   logic                   r_valid;
   logic [AXIL_DATA_W-1:0] r_data;
   axil_resp_e             r_resp;
   logic                   wr_fire;    // Address and data accepted
   logic                   rd_fire;
   logic                   wr_ctrl;
   logic [AXIL_DATA_W-1:0] rd_value;
   axil_resp_e             rd_code;

   assign wr_fire = aw_rdy & axil_req.awvalid & axil_req.wvalid;
   assign rd_fire = ar_rdy & axil_req.arvalid;
   assign wr_ctrl = (axil_req.awaddr == CTRL_ADDR);

   // ##########################################################
   // Write channel
   // ##########################################################

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         aw_rdy  <= 1'b0;
         b_valid <= 1'b0;
      end
      else
      begin
         // One-cycle ready once both halves are present, none while B is pending
         aw_rdy <= axil_req.awvalid & axil_req.wvalid & ~b_valid & ~aw_rdy;
         if (wr_fire)
            b_valid <= 1'b1;
         else if (axil_req.bready)
            b_valid <= 1'b0;   // Held until the master takes it
      end
   end

   always_ff @(posedge sys_clk)
   begin
      if (wr_fire)
         b_resp <= wr_ctrl ? OKAY : SLVERR;   // STATUS is read only
   end

   // CTRL register, receiver held after reset
   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
         soft_reset <= 1'b1;
      else if (wr_fire && wr_ctrl && axil_req.wstrb[0])
         soft_reset <= axil_req.wdata[0];
   end

   // ##########################################################
   // Read channel
   // ##########################################################

   // Address decode for read data and response
   always_comb
   begin
      rd_value = '0;
      rd_code  = OKAY;
      case (axil_req.araddr)
         CTRL_ADDR:
            rd_value = {{(AXIL_DATA_W-1){1'b0}}, soft_reset};
         STATUS_ADDR:
            rd_value = {{(AXIL_DATA_W-STATUS_W){1'b0}}, status};
         default:
            rd_code = SLVERR;   // Unmapped, data stays zero
      endcase
   end

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         ar_rdy  <= 1'b0;
         r_valid <= 1'b0;
      end
      else
      begin
         ar_rdy <= axil_req.arvalid & ~r_valid & ~ar_rdy;
         if (rd_fire)
            r_valid <= 1'b1;
         else if (axil_req.rready)
            r_valid <= 1'b0;
      end
   end

   // Read payload captured on acceptance
   always_ff @(posedge sys_clk)
   begin
      if (rd_fire)
      begin
         r_data <= rd_value;
         r_resp <= rd_code;
      end
   end

   // Response bundle
   always_comb
   begin
      axil_rsp.awready = aw_rdy;
      axil_rsp.wready  = aw_rdy;
      axil_rsp.bvalid  = b_valid;
      axil_rsp.bresp   = b_resp;
      axil_rsp.arready = ar_rdy;
      axil_rsp.rvalid  = r_valid;
      axil_rsp.rdata   = r_data;
      axil_rsp.rresp   = r_resp;
   end

endmodule

//--- src/erx_clock_gen.sv
`timescale 1ns/1ps

module erx_clock_gen (
   input  logic rx_clkin,      // Link clock from the pins
   input  logic pll_reset,     // Active high, from the sequencer
   output logic rx_lclk,       // High-speed clock, 1:1 with rx_clkin
   output logic rx_lclk_div4,  // Logic clock, quarter rate
   output logic pll_locked,
   output logic idelay_ready
);

   import erx_pkg::*;

   logic [LOCK_CNT_W-1:0] lock_cnt;  // Cycles since reset release
   logic                  lclk_en;   // Gate enable, changes while rx_clkin is low
   logic [1:0]            div_cnt;

   // ##########################################################
   // Lock and delay-ready model
   // ##########################################################

   always_ff @(posedge rx_clkin or posedge pll_reset)
   begin
      if (pll_reset)
      begin
         lock_cnt     <= '0;
         pll_locked   <= 1'b0;
         idelay_ready <= 1'b0;
      end
      else
      begin
         // Saturates once both flags are up
         if (lock_cnt != LOCK_CNT_W'(LOCK_TOTAL_CYCLES))
            lock_cnt <= lock_cnt + 1'b1;
         if (lock_cnt == LOCK_CNT_W'(PLL_LOCK_CYCLES - 1))
            pll_locked <= 1'b1;
         if (lock_cnt == LOCK_CNT_W'(LOCK_TOTAL_CYCLES - 1))
            idelay_ready <= 1'b1;   // Delay controller follows lock
      end
   end

   // ##########################################################
   // Output clocks
   // ##########################################################

   // Enable taken on the falling edge so the gate cannot chop a high phase
   always_ff @(negedge rx_clkin or posedge pll_reset)
   begin
      if (pll_reset)
         lclk_en <= 1'b0;
      else
         lclk_en <= pll_locked;
   end

   assign rx_lclk = rx_clkin & lclk_en;  // No multiplication in this model

   // Two-bit divider, MSB toggles every second cycle
   always_ff @(posedge rx_clkin or posedge pll_reset)
   begin
      if (pll_reset)
         div_cnt <= 2'b00;
      else if (!pll_locked)
         div_cnt <= 2'b00;                 // Held low until lock
      else
         div_cnt <= div_cnt + 1'b1;
   end

   assign rx_lclk_div4 = div_cnt[1];

endmodule

//--- src/erx_clocks.sv
`timescale 1ns/1ps

module erx_clocks (
   input  logic               sys_clk,        // Always-on system clock
   input  logic               rx_nreset_in,   // Hardware reset, active low
   input  logic               tx_active,      // Transmit side link up
   input  logic               rx_clkin,       // Receive link clock
   input  erx_pkg::axil_req_t axil_req,
   output erx_pkg::axil_rsp_t axil_rsp,
   output logic               rx_lclk,        // High-speed IO clock
   output logic               rx_lclk_div4,   // Core logic clock
   output logic               rx_active,
   output logic               erx_nreset,     // Core reset, rx_lclk_div4 domain
   output logic               erx_io_nreset   // IO reset, rx_lclk domain
);

   import erx_pkg::*;

   logic       soft_reset;
   logic       pll_reset;
   logic       pll_locked;     // rx_clkin domain
   logic       idelay_ready;   // rx_clkin domain
   logic       rx_nreset;      // sys_clk domain
   rx_status_t status;

   // ##########################################################
   // Host registers and sequencer
   // ##########################################################

   erx_cfg_regs u_cfg_regs (
      .sys_clk      (sys_clk),
      .rx_nreset_in (rx_nreset_in),
      .axil_req     (axil_req),
      .axil_rsp     (axil_rsp),
      .status       (status),
      .soft_reset   (soft_reset)
   );

   erx_reset_seq u_reset_seq (
      .sys_clk      (sys_clk),
      .rx_nreset_in (rx_nreset_in),
      .tx_active    (tx_active),
      .soft_reset   (soft_reset),
      .pll_locked   (pll_locked),
      .idelay_ready (idelay_ready),
      .pll_reset    (pll_reset),
      .rx_nreset    (rx_nreset),
      .status       (status)
   );

   assign rx_active = status.rx_active;

   // ##########################################################
   // Clocks and per-domain resets
   // ##########################################################

   erx_clock_gen u_clock_gen (
      .rx_clkin     (rx_clkin),
      .pll_reset    (pll_reset),
      .rx_lclk      (rx_lclk),
      .rx_lclk_div4 (rx_lclk_div4),
      .pll_locked   (pll_locked),
      .idelay_ready (idelay_ready)
   );

   // IO reset on the fast clock
   erx_reset_sync u_rsync_io (
      .clk      (rx_lclk),
      .nrst_in  (rx_nreset),
      .nrst_out (erx_io_nreset)
   );

   // Core reset on the divided clock
   erx_reset_sync u_rsync_core (
      .clk      (rx_lclk_div4),
      .nrst_in  (rx_nreset),
      .nrst_out (erx_nreset)
   );

endmodule

//--- src/erx_pkg.sv
package erx_pkg;

   // ##########################################################
   // Reset sequencer timing
   // ##########################################################

   localparam int RCW              = 4;         // Heartbeat counter width
   localparam int HEARTBEAT_PERIOD = 2 ** RCW;  // sys_clk cycles per heartbeat

   // Behavioral PLL timing, in rx_clkin cycles
   localparam int PLL_LOCK_CYCLES     = 24;     // Reset release to lock
   localparam int IDELAY_READY_CYCLES = 8;      // Lock to delay-controller ready
   localparam int LOCK_TOTAL_CYCLES   = PLL_LOCK_CYCLES + IDELAY_READY_CYCLES;
   localparam int LOCK_CNT_W          = $clog2(LOCK_TOTAL_CYCLES + 1);

   localparam int SYNC_STAGES = 2;              // Flops per synchronizer

   // ##########################################################
   // Register port
   // ##########################################################

   localparam int AXIL_ADDR_W = 4;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // Register map
   localparam logic [AXIL_ADDR_W-1:0] CTRL_ADDR   = 4'h0;
   localparam logic [AXIL_ADDR_W-1:0] STATUS_ADDR = 4'h4;

   // Sequencer states
   typedef enum logic [1:0] {
      RX_RESET_ALL = 2'b00,  // PLL and receiver held in reset
      RX_START_PLL = 2'b01,  // Waiting on lock and delay ready
      RX_ACTIVE    = 2'b10   // Receiver released
   } rx_reset_state_e;

   // AXI4-Lite response codes
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axil_resp_e;

   // Master to slave
   typedef struct packed {
      logic                   awvalid;
      logic [AXIL_ADDR_W-1:0] awaddr;
      logic                   wvalid;
      logic [AXIL_DATA_W-1:0] wdata;
      logic [AXIL_STRB_W-1:0] wstrb;
      logic                   bready;
      logic                   arvalid;
      logic [AXIL_ADDR_W-1:0] araddr;
      logic                   rready;
   } axil_req_t;

   // Slave to master
   typedef struct packed {
      logic                   awready;
      logic                   wready;
      logic                   bvalid;
      axil_resp_e             bresp;
      logic                   arready;
      logic                   rvalid;
      logic [AXIL_DATA_W-1:0] rdata;
      axil_resp_e             rresp;
   } axil_rsp_t;

   // Status word, state in the top bits
   typedef struct packed {
      rx_reset_state_e state;
      logic            pll_locked;
      logic            idelay_ready;
      logic            rx_active;
   } rx_status_t;

   localparam int STATUS_W = $bits(rx_status_t);  // 5 bits

endpackage

//--- src/erx_reset_seq.sv
`timescale 1ns/1ps

module erx_reset_seq (
   input  logic               sys_clk,
   input  logic               rx_nreset_in,
   input  logic               tx_active,     // Link up from transmit side
   input  logic               soft_reset,    // Host hold, sys_clk domain
   input  logic               pll_locked,    // rx_clkin domain
   input  logic               idelay_ready,  // rx_clkin domain
   output logic               pll_reset,
   output logic               rx_nreset,
   output erx_pkg::rx_status_t status
);

   import erx_pkg::*;

   logic [RCW-1:0]         hb_cnt;      // Free-running heartbeat counter
   logic                   heartbeat;   // One cycle per wrap
   logic [1:0]             flag_sync [SYNC_STAGES];  // {locked, ready} per stage
   logic                   locked_sync;
   logic                   ready_sync;
   rx_reset_state_e        state;
   logic                   active;

   // ##########################################################
   // Heartbeat
   // ##########################################################

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         hb_cnt    <= '0;
         heartbeat <= 1'b0;
      end
      else
      begin
         hb_cnt    <= hb_cnt + 1'b1;
         heartbeat <= (hb_cnt == RCW'(HEARTBEAT_PERIOD - 1));  // Fires on wrap
      end
   end

   // Lock and ready flags into sys_clk
   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         for (int i = 0; i < SYNC_STAGES; i++)
            flag_sync[i] <= 2'b00;
      end
      else
      begin
         flag_sync[0] <= {pll_locked, idelay_ready};
         for (int i = 1; i < SYNC_STAGES; i++)
            flag_sync[i] <= flag_sync[i-1];
      end
   end

   assign locked_sync = flag_sync[SYNC_STAGES-1][1];
   assign ready_sync  = flag_sync[SYNC_STAGES-1][0];

   // ##########################################################
   // Sequencer
   // ##########################################################

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
         state <= RX_RESET_ALL;
      else if (!tx_active)
         state <= RX_RESET_ALL;             // Link drop skips the heartbeat
      else if (heartbeat)
      begin
         case (state)
            RX_RESET_ALL:
               if (!soft_reset)
                  state <= RX_START_PLL;
            RX_START_PLL:
               if (locked_sync && ready_sync)
                  state <= RX_ACTIVE;
            RX_ACTIVE:
               if (soft_reset)
                  state <= RX_RESET_ALL;    // Host hold
            default:
               state <= RX_RESET_ALL;
         endcase
      end
   end

   assign active    = (state == RX_ACTIVE);
   assign pll_reset = (state == RX_RESET_ALL);  // PLL and delay ctrl in reset

   // Receiver reset one cycle behind rx_active
   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
         rx_nreset <= 1'b0;
      else
         rx_nreset <= active;
   end

   assign status = '{state: state, pll_locked: locked_sync,
                     idelay_ready: ready_sync, rx_active: active};

endmodule

//--- src/erx_reset_sync.sv
`timescale 1ns/1ps

module erx_reset_sync (
   input  logic clk,       // Destination domain clock
   input  logic nrst_in,   // Active low, any domain
   output logic nrst_out   // Active low, released on clk
);

   import erx_pkg::*;

   logic [SYNC_STAGES-1:0] chain;

   // Assert at once, shift ones in for release
   always_ff @(posedge clk or negedge nrst_in)
   begin
      if (!nrst_in)
         chain <= '0;
      else
         chain <= {chain[SYNC_STAGES-2:0], 1'b1};
   end

   assign nrst_out = chain[SYNC_STAGES-1];  // Last stage only

endmodule

//--- verif/tb_erx_clocks.sv
`timescale 1ns/1ps

module tb_erx_clocks;

   import erx_pkg::*;

   // ##########################################################
   // Test constants
   // ##########################################################

   localparam int SYS_PERIOD      = 20;  // ns
   localparam int CLKIN_PERIOD    = 6;   // ns
   // Lock plus delay ready rounded up to sys_clk cycles
   localparam int LOCK_SYS_CYCLES =
      ((PLL_LOCK_CYCLES + IDELAY_READY_CYCLES) * CLKIN_PERIOD + SYS_PERIOD - 1) / SYS_PERIOD;
   localparam int RX_ACTIVE_BOUND = 4 * HEARTBEAT_PERIOD + LOCK_SYS_CYCLES;
   // rx_nreset lag plus sync stages on the slowest clock
   localparam int RST_SYNC_BOUND  = 2 + (SYNC_STAGES + 1) * 4 * CLKIN_PERIOD / SYS_PERIOD;
   localparam int OP_BOUND        = 12;  // One bus access with back-pressure
   localparam int N_RAND          = 32;  // Random register rounds
   localparam int WATCHDOG_CYCLES = 4 * RX_ACTIVE_BOUND + 2 * HEARTBEAT_PERIOD
                                  + (3 * N_RAND + 12) * OP_BOUND + 8 * RST_SYNC_BOUND + 300;

   typedef struct packed {
      axil_resp_e             resp;
      logic [AXIL_DATA_W-1:0] data;
   } rd_result_t;

   logic       sys_clk;
   logic       rx_nreset_in;
   logic       tx_active;
   logic       rx_clkin;
   axil_req_t  req;
   axil_rsp_t  rsp;
   logic       rx_lclk;
   logic       rx_lclk_div4;
   logic       rx_active;
   logic       erx_nreset;
   logic       erx_io_nreset;
   int         errors = 0;
   integer     seed;
   logic       ctrl_model;     // Expected CTRL bit 0
   rx_status_t exp_status;     // Expected STATUS contents
   rd_result_t exp_q[$];
   rd_result_t act_q[$];
   string      name_q[$];
   event       cmp_ev;         // New entries in the queues

   erx_clocks erx_clocks_i (
      .sys_clk       (sys_clk),
      .rx_nreset_in  (rx_nreset_in),
      .tx_active     (tx_active),
      .rx_clkin      (rx_clkin),
      .axil_req      (req),
      .axil_rsp      (rsp),
      .rx_lclk       (rx_lclk),
      .rx_lclk_div4  (rx_lclk_div4),
      .rx_active     (rx_active),
      .erx_nreset    (erx_nreset),
      .erx_io_nreset (erx_io_nreset)
   );

   initial
   begin
      sys_clk = 1'b0;
      forever #(SYS_PERIOD / 2) sys_clk = ~sys_clk;
   end

   initial
   begin
      rx_clkin = 1'b0;
      forever #(CLKIN_PERIOD / 2.0) rx_clkin = ~rx_clkin;  // Link clock
   end

   // ##########################################################
   // Reference model and compare
   // ##########################################################

   function automatic rd_result_t exp_read(input logic [AXIL_ADDR_W-1:0] addr,
                                           input logic ctrl, input rx_status_t st);
      rd_result_t r;
      r.data = '0;
      r.resp = OKAY;
      if (addr == CTRL_ADDR)
         r.data[0] = ctrl;            // Single stored bit
      else if (addr == STATUS_ADDR)
         r.data[STATUS_W-1:0] = st;
      else
         r.resp = SLVERR;             // Unmapped reads zero
      return r;
   endfunction

   initial
   begin
      rd_result_t e;
      rd_result_t a;
      string      n;
      forever
      begin
         @(cmp_ev);
         while (act_q.size() > 0)
         begin
            e = exp_q.pop_front();
            a = act_q.pop_front();
            n = name_q.pop_front();
            assert (a === e)
            else
            begin
               errors++;
               $display("Fail %s: expected resp %0d data %h, actual resp %0d data %h",
                        n, e.resp, e.data, a.resp, a.data);
            end
         end
      end
   end

   task automatic post_check(input string name, input rd_result_t exp_r, input rd_result_t act_r);
      exp_q.push_back(exp_r);
      act_q.push_back(act_r);
      name_q.push_back(name);
      -> cmp_ev;
   endtask

   task automatic check_bit(input string name, input logic exp_b, input logic act_b);
      post_check(name, rd_result_t'{OKAY, AXIL_DATA_W'(exp_b)},
                 rd_result_t'{OKAY, AXIL_DATA_W'(act_b)});
   endtask

   // ##########################################################
   // AXI4-Lite master
   // ##########################################################

   task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                             input logic [AXIL_DATA_W-1:0] data,
                             input logic [AXIL_STRB_W-1:0] strb, output axil_resp_e resp);
      int delay;
      delay = $unsigned($random(seed)) % 4;  // bready back-pressure
      @(posedge sys_clk);
      req.awvalid <= 1'b1;
      req.awaddr  <= addr;
      req.wvalid  <= 1'b1;
      req.wdata   <= data;
      req.wstrb   <= strb;
      do
         @(posedge sys_clk);
      while (!rsp.awready);
      check_bit("wready with awready", 1'b1, rsp.wready);
      req.awvalid <= 1'b0;
      req.wvalid  <= 1'b0;
      repeat (delay) @(posedge sys_clk);
      req.bready <= 1'b1;
      do
         @(posedge sys_clk);
      while (!rsp.bvalid);
      resp = rsp.bresp;
      req.bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output rd_result_t res);
      int delay;
      delay = $unsigned($random(seed)) % 4;  // rready back-pressure
      @(posedge sys_clk);
      req.arvalid <= 1'b1;
      req.araddr  <= addr;
      do
         @(posedge sys_clk);
      while (!rsp.arready);
      req.arvalid <= 1'b0;
      repeat (delay) @(posedge sys_clk);
      req.rready <= 1'b1;
      do
         @(posedge sys_clk);
      while (!rsp.rvalid);
      res.resp = rsp.rresp;
      res.data = rsp.rdata;
      req.rready <= 1'b0;
   endtask

   task automatic check_read(input logic [AXIL_ADDR_W-1:0] addr, input string name);
      rd_result_t act_r;
      axil_read(addr, act_r);
      post_check(name, exp_read(addr, ctrl_model, exp_status), act_r);
   endtask

   task automatic check_write(input logic [AXIL_ADDR_W-1:0] addr,
                              input logic [AXIL_DATA_W-1:0] data,
                              input logic [AXIL_STRB_W-1:0] strb, input string name);
      rd_result_t exp_r;
      rd_result_t act_r;
      exp_r.data = '0;
      exp_r.resp = (addr == CTRL_ADDR) ? OKAY : SLVERR;  // STATUS read only
      act_r.data = '0;
      axil_write(addr, data, strb, act_r.resp);
      if (addr == CTRL_ADDR && strb[0])
         ctrl_model = data[0];
      post_check(name, exp_r, act_r);
   endtask

   // Requests stay valid while B and R wait, none may be taken again
   task automatic backpressure_stall(input string name);
      int taken;
      taken = 0;
      @(posedge sys_clk);
      req.awvalid <= 1'b1;
      req.awaddr  <= CTRL_ADDR;
      req.wvalid  <= 1'b1;
      req.wdata   <= AXIL_DATA_W'(ctrl_model);  // Same value, CTRL unchanged
      req.wstrb   <= 4'h1;
      req.arvalid <= 1'b1;
      req.araddr  <= CTRL_ADDR;
      do
         @(posedge sys_clk);
      while (!(rsp.awready && rsp.arready));
      repeat (4)
      begin
         @(posedge sys_clk);
         if (rsp.awready || rsp.wready || rsp.arready)
            taken++;
      end
      req.awvalid <= 1'b0;
      req.wvalid  <= 1'b0;
      req.arvalid <= 1'b0;
      req.bready  <= 1'b1;
      req.rready  <= 1'b1;
      @(posedge sys_clk);
      req.bready  <= 1'b0;
      req.rready  <= 1'b0;
      check_bit(name, 1'b0, taken != 0);
   endtask

   // ##########################################################
   // Waits and clock checks
   // ##########################################################

   task automatic wait_active(input logic level, input int bound, input string name);
      int n;
      n = 0;
      while (rx_active !== level && n < bound)
      begin
         @(posedge sys_clk);
         n++;
      end
      assert (rx_active === level)
      else
      begin
         errors++;
         $display("%s: rx_active did not go to %0b within %0d cycles", name, level, bound);
      end
   endtask

   task automatic wait_resets(input logic level, input int bound, input string name);
      int n;
      n = 0;
      while ({erx_nreset, erx_io_nreset} !== {2{level}} && n < bound)
      begin
         @(posedge sys_clk);
         n++;
      end
      assert ({erx_nreset, erx_io_nreset} === {2{level}})
      else
      begin
         errors++;
         $display("%s: domain resets did not go to %0b within %0d cycles", name, level, bound);
      end
   endtask

   // Full bring-up then STATUS read
   task automatic activate(input string name);
      wait_active(1'b1, RX_ACTIVE_BOUND, name);
      wait_resets(1'b1, RST_SYNC_BOUND, name);
      exp_status = rx_status_t'{RX_ACTIVE, 1'b1, 1'b1, 1'b1};
      check_read(STATUS_ADDR, {name, " status"});
   endtask

   task automatic check_ratio();
      int   rises;
      logic prev;
      rises = 0;
      @(negedge rx_lclk);                    // div4 settled here
      prev = rx_lclk_div4;
      repeat (64)
      begin
         @(negedge rx_lclk);
         if (rx_lclk_div4 && !prev)
            rises++;
         prev = rx_lclk_div4;
      end
      assert (rises >= 15 && rises <= 17)
      else
      begin
         errors++;
         $display("Fail clock ratio: expected 16 +/- 1, actual %0d", rises);
      end
   endtask

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
      $display("Timeout after %0d sys_clk cycles, %0d errors", WATCHDOG_CYCLES, errors);
      $display("sim failed");
      $finish;
   end

   // ##########################################################
   // Test sequence
   // ##########################################################

   initial
   begin
      logic [AXIL_ADDR_W-1:0] addr;
      logic [AXIL_DATA_W-1:0] data;
      logic [AXIL_STRB_W-1:0] strb;
      logic [1:0]             sel;
      seed         = 32'h868fee61;
      rx_nreset_in = 1'b0;
      tx_active    = 1'b1;
      req          = '0;
      ctrl_model   = 1'b1;                   // Receiver held in reset
      exp_status   = rx_status_t'{RX_RESET_ALL, 1'b0, 1'b0, 1'b0};
      repeat (2) @(posedge sys_clk);
      rx_nreset_in <= 1'b1;
      @(posedge sys_clk);

      // Reset defaults
      check_bit("reset rx_active", 1'b0, rx_active);
      check_bit("reset erx_nreset", 1'b0, erx_nreset);
      check_bit("reset erx_io_nreset", 1'b0, erx_io_nreset);
      check_bit("reset rx_lclk", 1'b0, rx_lclk);
      check_bit("reset rx_lclk_div4", 1'b0, rx_lclk_div4);
      check_read(CTRL_ADDR, "reset ctrl");
      check_read(STATUS_ADDR, "reset status");

      // Activation and clock ratio
      check_write(CTRL_ADDR, 32'h0, 4'hf, "release write");
      activate("activation");
      check_ratio();

      // Soft reset and back
      check_write(CTRL_ADDR, 32'h1, 4'h1, "soft reset write");
      wait_active(1'b0, 2 * HEARTBEAT_PERIOD, "soft reset");
      wait_resets(1'b0, RST_SYNC_BOUND, "soft reset");
      check_write(CTRL_ADDR, 32'h0, 4'h1, "rerelease write");
      activate("soft reset reactivation");

      // Link drop pins the state to reset-all
      @(posedge sys_clk);
      tx_active <= 1'b0;
      wait_active(1'b0, 2, "link drop");
      wait_resets(1'b0, RST_SYNC_BOUND, "link drop");
      exp_status = rx_status_t'{RX_RESET_ALL, 1'b0, 1'b0, 1'b0};

      // Register rules while the link is down
      repeat (N_RAND)
      begin
         sel  = 2'($random(seed));
         addr = AXIL_ADDR_W'($random(seed));
         data = $random(seed);
         strb = AXIL_STRB_W'($random(seed));
         if (sel == 2'd0)
            addr = CTRL_ADDR;
         else if (sel == 2'd1)
            addr = STATUS_ADDR;
         check_write(addr, data, strb, "random write");
         check_read(addr, "random read");
         check_read(CTRL_ADDR, "random ctrl read");
      end
      backpressure_stall("back-pressure stall");
      check_read(CTRL_ADDR, "stall ctrl read");

      // Link restore
      check_write(CTRL_ADDR, 32'h0, 4'h1, "restore write");
      @(posedge sys_clk);
      tx_active <= 1'b1;
      activate("link restore");

      repeat (2) @(posedge sys_clk);          // Let the compare queue drain
      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule
